//--- design/pkt_mon_pkg.sv
/* widths, register map and checker states shared by the stream packet monitor
   every design module imports what it needs from here */
`default_nettype none

package pkt_mon_pkg;

    // stream array geometry
    localparam int num_ports = 4;
    localparam int data_bytes = 4;

    typedef logic [data_bytes*8-1:0] axis_data_t;
    typedef logic [data_bytes-1:0]   axis_keep_t;

    // packet length in bytes and statistics counter
    typedef logic [15:0] pkt_len_t;
    typedef logic [31:0] cnt_t;

    // AXI4-Lite register bus
    typedef logic [7:0]  reg_addr_t;
    typedef logic [31:0] reg_data_t;

    localparam logic [1:0] resp_okay = 2'b00;

    // register map
    localparam reg_addr_t ctrl_addr = 8'h00;
    localparam reg_addr_t mtu_addr = 8'h04;
    localparam reg_addr_t port_base = 8'h10;
    localparam reg_addr_t port_stride = 8'h10;

    // offsets inside one port block
    localparam reg_addr_t good_ofs = 8'h0;
    localparam reg_addr_t data_err_ofs = 8'h4;
    localparam reg_addr_t len_err_ofs = 8'h8;
    localparam reg_addr_t bytes_ofs = 8'hC;

    // length limit after reset
    localparam pkt_len_t mtu_reset = 16'd64;

    // drop means the packet already failed but is still being counted
    typedef enum logic [1:0] {
        idle,
        in_pkt,
        drop
    } chk_state_t;

endpackage

`default_nettype wire

//--- design/axis_pkt_checker.sv
/* packet checker for one AXI4-Stream port: follows incrementing payload bytes,
   sums the length and gives one result pulse per packet, a cycle after tlast */
`timescale 1ns/100ps
`default_nettype none

module axis_pkt_checker (
    input  wire logic                    axis_in,
    input  wire logic                    arst_n,
    input  wire logic                    tvalid,
    input  wire logic                    tready,
    input  wire pkt_mon_pkg::axis_data_t tdata,
    input  wire pkt_mon_pkg::axis_keep_t tkeep,
    input  wire logic                    tlast,
    input  wire pkt_mon_pkg::pkt_len_t   mtu_limit,
    output logic                         pkt_good,
    output logic                         pkt_data_err,
    output logic                         pkt_len_err,
    output pkt_mon_pkg::pkt_len_t        pkt_bytes
);
    import pkt_mon_pkg::*;

    chk_state_t state;
    logic [7:0] exp_byte;
    pkt_len_t   byte_cnt;

    logic       beat;
    logic [7:0] base_byte;
    pkt_len_t   base_cnt;
    pkt_len_t   beat_bytes;
    logic [16:0] byte_sum;
    pkt_len_t   run_bytes;
    logic       lane_err;
    logic       beat_err;
    logic       pkt_failed;

    // number of set tkeep bits, holes in the mask are not special
    function automatic pkt_len_t keep_count(input axis_keep_t keep);
        pkt_len_t n;
        n = '0;
        for (int i = 0; i < data_bytes; i++) begin
            n = n + pkt_len_t'(keep[i]);
        end
        return n;
    endfunction

    assign beat = tvalid & tready;

    // first beat seeds the expected sequence from its own lane 0
    assign base_byte = (state == idle) ? tdata[7:0] : exp_byte;
    assign base_cnt = (state == idle) ? '0 : byte_cnt;
    assign beat_bytes = keep_count(tkeep);

    // saturate so an endless packet cannot wrap below the limit
    assign byte_sum = {1'b0, base_cnt} + {1'b0, beat_bytes};
    assign run_bytes = byte_sum[16] ? '1 : byte_sum[15:0];

    always_comb begin
        lane_err = 1'b0;
        for (int i = 0; i < data_bytes; i++) begin
            if (tkeep[i] && (tdata[i*8 +: 8] != 8'(base_byte + i))) begin
                lane_err = 1'b1;
            end
        end
    end

    // only the final beat may be partial
    assign beat_err = lane_err | (~tlast & (tkeep != '1));
    assign pkt_failed = (state == drop) | beat_err;

    always_ff @(posedge axis_in or negedge arst_n) begin
        if (!arst_n) begin
            state <= idle;
            exp_byte <= '0;
            byte_cnt <= '0;
        end else if (beat) begin
            exp_byte <= base_byte + beat_bytes[7:0];
            byte_cnt <= run_bytes;
            case (state)
                idle, in_pkt: begin
                    if (tlast)
                        state <= idle;
                    else if (beat_err)
                        state <= drop;
                    else
                        state <= in_pkt;
                end
                drop: begin
                    if (tlast)
                        state <= idle;
                end
                default: state <= idle;
            endcase
        end
    end

    // result stage, a length error hides a data error
    always_ff @(posedge axis_in or negedge arst_n) begin
        if (!arst_n) begin
            pkt_good <= 1'b0;
            pkt_data_err <= 1'b0;
            pkt_len_err <= 1'b0;
        end else begin
            pkt_good <= 1'b0;
            pkt_data_err <= 1'b0;
            pkt_len_err <= 1'b0;
            if (beat && tlast) begin
                if (run_bytes > mtu_limit)
                    pkt_len_err <= 1'b1;
                else if (pkt_failed)
                    pkt_data_err <= 1'b1;
                else
                    pkt_good <= 1'b1;
            end
        end
    end

    always_ff @(posedge axis_in) begin
        if (beat && tlast)
            pkt_bytes <= run_bytes;
    end

endmodule

`default_nettype wire

//--- design/pkt_mon_regs.sv
/* AXI4-Lite register slave of the packet monitor: length limit, counter clear
   and four saturating statistics counters per port */
`timescale 1ns/100ps
`default_nettype none

module pkt_mon_regs (
    input  wire logic                                  axis_in,
    input  wire logic                                  arst_n,
    input  wire logic [pkt_mon_pkg::num_ports-1:0]     good,
    input  wire logic [pkt_mon_pkg::num_ports-1:0]     data_err,
    input  wire logic [pkt_mon_pkg::num_ports-1:0]     len_err,
    input  wire pkt_mon_pkg::pkt_len_t                 bytes [pkt_mon_pkg::num_ports],
    output pkt_mon_pkg::pkt_len_t                      mtu_limit,
    input  wire logic                                  awvalid,
    output logic                                       awready,
    input  wire pkt_mon_pkg::reg_addr_t                awaddr,
    input  wire logic                                  wvalid,
    output logic                                       wready,
    input  wire pkt_mon_pkg::reg_data_t                wdata,
    output logic                                       bvalid,
    input  wire logic                                  bready,
    output logic [1:0]                                 bresp,
    input  wire logic                                  arvalid,
    output logic                                       arready,
    input  wire pkt_mon_pkg::reg_addr_t                araddr,
    output logic                                       rvalid,
    input  wire logic                                  rready,
    output pkt_mon_pkg::reg_data_t                     rdata,
    output logic [1:0]                                 rresp
);
    import pkt_mon_pkg::*;

    cnt_t good_cnt [num_ports];
    cnt_t data_err_cnt [num_ports];
    cnt_t len_err_cnt [num_ports];
    cnt_t bytes_cnt [num_ports];

    logic      wr_fire;
    logic      ar_fire;
    logic      r_fire;
    logic      clear;
    reg_data_t rd_mux;

    function automatic cnt_t sat_add(input cnt_t a, input cnt_t b);
        logic [32:0] s;
        s = {1'b0, a} + {1'b0, b};
        return s[32] ? '1 : s[31:0];
    endfunction

    // address and data are taken together, one write at a time
    assign awready = awvalid & wvalid & ~bvalid;
    assign wready = awready;
    assign wr_fire = awready;
    assign bresp = resp_okay;
    assign rresp = resp_okay;

    assign clear = wr_fire && (awaddr == ctrl_addr) && wdata[0];

    always_ff @(posedge axis_in or negedge arst_n) begin
        if (!arst_n) begin
            bvalid <= 1'b0;
            mtu_limit <= mtu_reset;
        end else begin
            if (wr_fire)
                bvalid <= 1'b1;
            else if (bready)
                bvalid <= 1'b0;
            if (wr_fire && (awaddr == mtu_addr))
                mtu_limit <= wdata[15:0];
        end
    end

    // clear takes priority over a result landing in the same cycle
    always_ff @(posedge axis_in or negedge arst_n) begin
        if (!arst_n) begin
            for (int p = 0; p < num_ports; p++) begin
                good_cnt[p] <= '0;
                data_err_cnt[p] <= '0;
                len_err_cnt[p] <= '0;
                bytes_cnt[p] <= '0;
            end
        end else if (clear) begin
            for (int p = 0; p < num_ports; p++) begin
                good_cnt[p] <= '0;
                data_err_cnt[p] <= '0;
                len_err_cnt[p] <= '0;
                bytes_cnt[p] <= '0;
            end
        end else begin
            for (int p = 0; p < num_ports; p++) begin
                if (good[p])
                    good_cnt[p] <= sat_add(good_cnt[p], cnt_t'(1));
                if (data_err[p])
                    data_err_cnt[p] <= sat_add(data_err_cnt[p], cnt_t'(1));
                if (len_err[p])
                    len_err_cnt[p] <= sat_add(len_err_cnt[p], cnt_t'(1));
                // every finished packet adds its bytes, failed or not
                if (good[p] || data_err[p] || len_err[p])
                    bytes_cnt[p] <= sat_add(bytes_cnt[p], cnt_t'(bytes[p]));
            end
        end
    end

    assign ar_fire = arvalid & arready;
    assign r_fire = rvalid & rready;

    // arready stays low while a read response waits
    always_ff @(posedge axis_in or negedge arst_n) begin
        if (!arst_n) begin
            arready <= 1'b0;
            rvalid <= 1'b0;
        end else if (ar_fire) begin
            arready <= 1'b0;
            rvalid <= 1'b1;
        end else begin
            if (r_fire)
                rvalid <= 1'b0;
            arready <= ~rvalid | r_fire;
        end
    end

    // ctrl and unmapped addresses read as zero
    always_comb begin
        rd_mux = '0;
        if (araddr == mtu_addr)
            rd_mux = reg_data_t'(mtu_limit);
        for (int p = 0; p < num_ports; p++) begin
            if (araddr == reg_addr_t'(port_base + p*port_stride + good_ofs))
                rd_mux = good_cnt[p];
            if (araddr == reg_addr_t'(port_base + p*port_stride + data_err_ofs))
                rd_mux = data_err_cnt[p];
            if (araddr == reg_addr_t'(port_base + p*port_stride + len_err_ofs))
                rd_mux = len_err_cnt[p];
            if (araddr == reg_addr_t'(port_base + p*port_stride + bytes_ofs))
                rd_mux = bytes_cnt[p];
        end
    end

    always_ff @(posedge axis_in) begin
        if (ar_fire)
            rdata <= rd_mux;
    end

endmodule

`default_nettype wire

//--- design/axis_array_pkt_mon.sv
/* top of the passive monitor for an array of AXI4-Stream ports
   one checker per port feeds the shared AXI4-Lite statistics block */
`timescale 1ns/100ps
`default_nettype none

module axis_array_pkt_mon (
    input  wire logic                                axis_in,
    input  wire logic                                arst_n,
    input  wire logic [pkt_mon_pkg::num_ports-1:0]   s_tvalid,
    input  wire logic [pkt_mon_pkg::num_ports-1:0]   s_tready,
    input  wire pkt_mon_pkg::axis_data_t             s_tdata [pkt_mon_pkg::num_ports],
    input  wire pkt_mon_pkg::axis_keep_t             s_tkeep [pkt_mon_pkg::num_ports],
    input  wire logic [pkt_mon_pkg::num_ports-1:0]   s_tlast,
    input  wire logic                                awvalid,
    output logic                                     awready,
    input  wire pkt_mon_pkg::reg_addr_t              awaddr,
    input  wire logic                                wvalid,
    output logic                                     wready,
    input  wire pkt_mon_pkg::reg_data_t              wdata,
    output logic                                     bvalid,
    input  wire logic                                bready,
    output logic [1:0]                               bresp,
    input  wire logic                                arvalid,
    output logic                                     arready,
    input  wire pkt_mon_pkg::reg_addr_t              araddr,
    output logic                                     rvalid,
    input  wire logic                                rready,
    output pkt_mon_pkg::reg_data_t                   rdata,
    output logic [1:0]                               rresp
);
    import pkt_mon_pkg::*;

    // per-port result pulses and their byte counts
    logic [num_ports-1:0] pkt_good;
    logic [num_ports-1:0] pkt_data_err;
    logic [num_ports-1:0] pkt_len_err;
    pkt_len_t             pkt_bytes [num_ports];
    pkt_len_t             mtu_limit;

    for (genvar p = 0; p < num_ports; p++) begin : g_chk
        axis_pkt_checker u_chk (
            .axis_in      (axis_in),
            .arst_n       (arst_n),
            .tvalid       (s_tvalid[p]),
            .tready       (s_tready[p]),
            .tdata        (s_tdata[p]),
            .tkeep        (s_tkeep[p]),
            .tlast        (s_tlast[p]),
            .mtu_limit    (mtu_limit),
            .pkt_good     (pkt_good[p]),
            .pkt_data_err (pkt_data_err[p]),
            .pkt_len_err  (pkt_len_err[p]),
            .pkt_bytes    (pkt_bytes[p])
        );
    end

    pkt_mon_regs u_regs (
        .axis_in   (axis_in),
        .arst_n    (arst_n),
        .good      (pkt_good),
        .data_err  (pkt_data_err),
        .len_err   (pkt_len_err),
        .bytes     (pkt_bytes),
        .mtu_limit (mtu_limit),
        .awvalid   (awvalid),
        .awready   (awready),
        .awaddr    (awaddr),
        .wvalid    (wvalid),
        .wready    (wready),
        .wdata     (wdata),
        .bvalid    (bvalid),
        .bready    (bready),
        .bresp     (bresp),
        .arvalid   (arvalid),
        .arready   (arready),
        .araddr    (araddr),
        .rvalid    (rvalid),
        .rready    (rready),
        .rdata     (rdata),
        .rresp     (rresp)
    );

endmodule

`default_nettype wire

//--- dv/axis_array_pkt_mon_assert.sv
/* concurrent checks bound into the monitor top: AXI4-Lite responses hold until
   accepted, and each checker gives one result pulse a cycle after every tlast */
`timescale 1ns/100ps
`default_nettype none

module axis_array_pkt_mon_assert (
    input wire logic                              axis_in,
    input wire logic                              arst_n,
    input wire logic [pkt_mon_pkg::num_ports-1:0] s_tvalid,
    input wire logic [pkt_mon_pkg::num_ports-1:0] s_tready,
    input wire logic [pkt_mon_pkg::num_ports-1:0] s_tlast,
    input wire logic [pkt_mon_pkg::num_ports-1:0] pkt_good,
    input wire logic [pkt_mon_pkg::num_ports-1:0] pkt_data_err,
    input wire logic [pkt_mon_pkg::num_ports-1:0] pkt_len_err,
    input wire logic                              bvalid,
    input wire logic                              bready,
    input wire logic                              rvalid,
    input wire logic                              rready
);
    import pkt_mon_pkg::*;

    assert property (@(posedge axis_in) disable iff (!arst_n) bvalid && !bready |=> bvalid)
        else $error("bvalid dropped before bready");
    assert property (@(posedge axis_in) disable iff (!arst_n) rvalid && !rready |=> rvalid)
        else $error("rvalid dropped before rready");

    for (genvar p = 0; p < num_ports; p++) begin : g_port
        assert property (@(posedge axis_in) disable iff (!arst_n)
            $onehot0({pkt_good[p], pkt_data_err[p], pkt_len_err[p]}))
            else $error("port %0d gave more than one result in a cycle", p);
        // every accepted tlast gives a result on the next edge, and nothing else does
        assert property (@(posedge axis_in) disable iff (!arst_n)
            s_tvalid[p] && s_tready[p] && s_tlast[p]
            |=> (pkt_good[p] || pkt_data_err[p] || pkt_len_err[p]))
            else $error("port %0d missed a result after tlast", p);
        assert property (@(posedge axis_in) disable iff (!arst_n)
            (pkt_good[p] || pkt_data_err[p] || pkt_len_err[p])
            |-> $past(s_tvalid[p] && s_tready[p] && s_tlast[p]))
            else $error("port %0d gave a result without a tlast handshake", p);
    end

endmodule

`default_nettype wire

//--- dv/tb_axis_array_pkt_mon.sv
/* testbench for the stream packet monitor with random packets on all four ports,
   a reference model of the counters and AXI4-Lite reads that compare against it */
`timescale 1ns/100ps
`default_nettype none

module tb_axis_array_pkt_mon;
    import pkt_mon_pkg::*;

    localparam int timeout_cycles = 50;
    localparam int max_beats = 20;

    logic                 axis_in;
    logic                 arst_n;
    logic [num_ports-1:0] s_tvalid;
    logic [num_ports-1:0] s_tready;
    logic [num_ports-1:0] s_tlast;
    axis_data_t           s_tdata [num_ports];
    axis_keep_t           s_tkeep [num_ports];
    logic                 awvalid;
    logic                 awready;
    reg_addr_t            awaddr;
    logic                 wvalid;
    logic                 wready;
    reg_data_t            wdata;
    logic                 bvalid;
    logic                 bready;
    logic [1:0]           bresp;
    logic                 arvalid;
    logic                 arready;
    reg_addr_t            araddr;
    logic                 rvalid;
    logic                 rready;
    reg_data_t            rdata;
    logic [1:0]           rresp;

    int         seed;
    reg_data_t  rd_val;

    // packet being sent on each port
    axis_data_t beat_data [num_ports][max_beats];
    axis_keep_t beat_keep [num_ports][max_beats];
    int         beat_num [num_ports];
    int         beat_idx [num_ports];

    // reference model state and expected counters
    int         m_len [num_ports];
    bit         m_err [num_ports];
    bit         m_start [num_ports];
    bit         m_have [num_ports];
    logic [7:0] m_exp [num_ports];
    int         mtu_model;
    int         exp_good [num_ports];
    int         exp_derr [num_ports];
    int         exp_lerr [num_ports];
    int         exp_bytes [num_ports];

    axis_array_pkt_mon DUT (.*);

    bind axis_array_pkt_mon axis_array_pkt_mon_assert u_assert (
        .axis_in      (axis_in),
        .arst_n       (arst_n),
        .s_tvalid     (s_tvalid),
        .s_tready     (s_tready),
        .s_tlast      (s_tlast),
        .pkt_good     (pkt_good),
        .pkt_data_err (pkt_data_err),
        .pkt_len_err  (pkt_len_err),
        .bvalid       (bvalid),
        .bready       (bready),
        .rvalid       (rvalid),
        .rready       (rready)
    );

    initial axis_in = 1'b0;
    always #50 axis_in = ~axis_in;

    task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            $display("Error: %s: expected 0x%08h, actual 0x%08h", name, exp, act);
            $display("*** FAILED ***");
            $fatal(1, "mismatch in %s", name);
        end
    endtask

    task automatic report_timeout(input string what);
        $display("Timeout: the DUT never completed the %s", what);
        $display("*** FAILED ***");
        $fatal(1, "timeout");
    endtask

    function automatic int rand_below(input int n);
        return int'($unsigned($random(seed)) % n);
    endfunction

    task automatic reg_write(input reg_addr_t addr, input reg_data_t data);
        int t;
        awaddr = addr;
        wdata = data;
        awvalid = 1'b1;
        wvalid = 1'b1;
        bready = 1'b1;
        t = 0;
        @(negedge axis_in);
        while (!(awready && wready)) begin
            t++;
            if (t > timeout_cycles)
                report_timeout("write address and data handshake");
            @(negedge axis_in);
        end
        @(posedge axis_in);
        #10;
        awvalid = 1'b0;
        wvalid = 1'b0;
        t = 0;
        @(negedge axis_in);
        while (!bvalid) begin
            t++;
            if (t > timeout_cycles)
                report_timeout("write response");
            @(negedge axis_in);
        end
        check_value("write response", 32'(resp_okay), 32'(bresp));
        @(posedge axis_in);
        #10;
        bready = 1'b0;
    endtask

    // stall holds rready low for that many cycles after rvalid rises
    task automatic reg_read(input reg_addr_t addr, input int stall, output reg_data_t data);
        int t;
        araddr = addr;
        arvalid = 1'b1;
        rready = 1'b0;
        t = 0;
        @(negedge axis_in);
        while (!arready) begin
            t++;
            if (t > timeout_cycles)
                report_timeout("read address handshake");
            @(negedge axis_in);
        end
        @(posedge axis_in);
        #10;
        arvalid = 1'b0;
        // read data is captured at the address handshake and must not follow araddr
        araddr = '0;
        t = 0;
        @(negedge axis_in);
        while (!rvalid) begin
            t++;
            if (t > timeout_cycles)
                report_timeout("read response");
            @(negedge axis_in);
        end
        data = rdata;
        check_value("read response", 32'(resp_okay), 32'(rresp));
        repeat (stall) begin
            @(negedge axis_in);
            check_value("rvalid held while stalled", 1, 32'(rvalid));
            check_value("rdata held while stalled", data, rdata);
        end
        @(posedge axis_in);
        #10;
        rready = 1'b1;
        @(posedge axis_in);
        #10;
        rready = 1'b0;
    endtask

    task automatic clear_model();
        for (int p = 0; p < num_ports; p++) begin
            exp_good[p] = 0;
            exp_derr[p] = 0;
            exp_lerr[p] = 0;
            exp_bytes[p] = 0;
        end
    endtask

    // apply the packet rules to one accepted beat
    task automatic model_beat(input int p, input axis_data_t data, input axis_keep_t keep,
                              input logic last);
        logic [7:0] b;
        if (m_start[p]) begin
            m_len[p] = 0;
            m_err[p] = 1'b0;
            m_have[p] = 1'b0;
        end
        for (int l = 0; l < data_bytes; l++) begin
            if (keep[l]) begin
                b = data[l*8 +: 8];
                if (m_have[p] && (b != m_exp[p]))
                    m_err[p] = 1'b1;
                m_exp[p] = b + 8'd1;
                m_have[p] = 1'b1;
                m_len[p]++;
            end
        end
        if (!last && (keep != 4'hF))
            m_err[p] = 1'b1;
        m_start[p] = last;
        if (last) begin
            if (m_len[p] > mtu_model)
                exp_lerr[p]++;
            else if (m_err[p])
                exp_derr[p]++;
            else
                exp_good[p]++;
            exp_bytes[p] += m_len[p];
        end
    endtask

    // incrementing payload, with a corrupted byte or a partial middle beat now and then
    task automatic build_packet(input int p, input int max_len, input int err_pct);
        int len;
        int nb;
        int idx;
        int bad;
        logic [7:0] b;
        len = 1 + rand_below(max_len);
        b = 8'($random(seed));
        nb = (len + 3) / 4;
        for (int i = 0; i < nb; i++) begin
            beat_data[p][i] = '0;
            beat_keep[p][i] = '0;
            for (int l = 0; l < data_bytes; l++) begin
                idx = i*4 + l;
                if (idx < len) begin
                    beat_data[p][i][l*8 +: 8] = b + 8'(idx);
                    beat_keep[p][i][l] = 1'b1;
                end
            end
        end
        if (rand_below(100) < err_pct) begin
            bad = rand_below(len);
            beat_data[p][bad/4][(bad%4)*8 +: 8] =
                beat_data[p][bad/4][(bad%4)*8 +: 8] ^ (8'($random(seed)) | 8'h01);
        end
        if ((nb >= 2) && (rand_below(100) < err_pct))
            beat_keep[p][rand_below(nb-1)] = 4'b0111;
        beat_num[p] = nb;
        beat_idx[p] = 0;
    endtask

    // all ports run together, with random gaps in both tvalid and tready
    task automatic run_traffic(input int pkts, input int max_len, input int err_pct);
        int  left [num_ports];
        bit  busy;
        logic v;
        logic r;
        for (int p = 0; p < num_ports; p++) begin
            left[p] = pkts;
            beat_num[p] = 0;
            beat_idx[p] = 0;
        end
        busy = 1'b1;
        while (busy) begin
            busy = 1'b0;
            for (int p = 0; p < num_ports; p++) begin
                if ((beat_idx[p] >= beat_num[p]) && (left[p] > 0)) begin
                    build_packet(p, max_len, err_pct);
                    left[p]--;
                end
                v = (rand_below(4) != 0);
                r = (rand_below(4) != 0);
                s_tready[p] = r;
                if ((beat_idx[p] < beat_num[p]) && v) begin
                    busy = 1'b1;
                    s_tvalid[p] = 1'b1;
                    s_tdata[p] = beat_data[p][beat_idx[p]];
                    s_tkeep[p] = beat_keep[p][beat_idx[p]];
                    s_tlast[p] = (beat_idx[p] == beat_num[p] - 1);
                    if (r) begin
                        model_beat(p, s_tdata[p], s_tkeep[p], s_tlast[p]);
                        beat_idx[p]++;
                    end
                end else begin
                    // idle lanes carry junk that must be ignored
                    if (beat_idx[p] < beat_num[p])
                        busy = 1'b1;
                    s_tvalid[p] = 1'b0;
                    s_tdata[p] = axis_data_t'($random(seed));
                    s_tkeep[p] = axis_keep_t'($random(seed));
                    s_tlast[p] = 1'($random(seed));
                end
            end
            if (busy) begin
                @(posedge axis_in);
                #10;
            end
        end
        // counters settle two cycles after the last tlast
        repeat (3) @(posedge axis_in);
        #10;
    endtask

    task automatic check_counters(input string phase);
        reg_data_t v;
        reg_addr_t base;
        for (int p = 0; p < num_ports; p++) begin
            base = reg_addr_t'(port_base + p*port_stride);
            reg_read(base + good_ofs, p % 3, v);
            check_value($sformatf("%s port %0d good", phase, p), exp_good[p], v);
            reg_read(base + data_err_ofs, 0, v);
            check_value($sformatf("%s port %0d data_err", phase, p), exp_derr[p], v);
            reg_read(base + len_err_ofs, 0, v);
            check_value($sformatf("%s port %0d len_err", phase, p), exp_lerr[p], v);
            reg_read(base + bytes_ofs, p % 2, v);
            check_value($sformatf("%s port %0d bytes", phase, p), exp_bytes[p], v);
        end
    endtask

    initial begin
        seed = 32'h5da6_6245;
        arst_n = 1'b0;
        s_tvalid = '0;
        s_tready = '0;
        s_tlast = '0;
        for (int p = 0; p < num_ports; p++) begin
            s_tdata[p] = '0;
            s_tkeep[p] = '0;
            m_start[p] = 1'b1;
            m_have[p] = 1'b0;
            m_len[p] = 0;
            m_err[p] = 1'b0;
            m_exp[p] = '0;
        end
        awvalid = 1'b0;
        awaddr = '0;
        wvalid = 1'b0;
        wdata = '0;
        bready = 1'b0;
        arvalid = 1'b0;
        araddr = '0;
        rready = 1'b0;
        mtu_model = 64;
        clear_model();
        repeat (3) @(posedge axis_in);
        #10;
        arst_n = 1'b1;

        reg_read(mtu_addr, 0, rd_val);
        check_value("mtu after reset", 64, rd_val);

        run_traffic(12, 64, 0);
        check_counters("clean traffic");

        run_traffic(16, 64, 30);
        check_counters("injected errors");

        reg_write(mtu_addr, 32);
        mtu_model = 32;
        reg_read(mtu_addr, 0, rd_val);
        check_value("mtu readback", 32, rd_val);
        run_traffic(16, 80, 25);
        check_counters("length limit");

        reg_write(ctrl_addr, 32'h1);
        clear_model();
        reg_read(ctrl_addr, 0, rd_val);
        check_value("ctrl readback", 0, rd_val);
        check_counters("after clear");
        run_traffic(8, 48, 20);
        check_counters("traffic after clear");

        // holes in the map and a long rready stall
        reg_read(8'h08, 0, rd_val);
        check_value("unmapped 0x08", 0, rd_val);
        reg_read(8'h50, 3, rd_val);
        check_value("unmapped 0x50", 0, rd_val);
        reg_read(reg_addr_t'(port_base + bytes_ofs), 5, rd_val);
        check_value("stalled read port 0 bytes", exp_bytes[0], rd_val);

        $display("*** PASSED ***");
        $finish;
    end

endmodule

`default_nettype wire

//--- sources.f
design/pkt_mon_pkg.sv
design/axis_pkt_checker.sv
design/pkt_mon_regs.sv
design/axis_array_pkt_mon.sv
dv/axis_array_pkt_mon_assert.sv
dv/tb_axis_array_pkt_mon.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build the monitor testbench with Verilator, run it and scan the log
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert \
    -f sources.f \
    --top-module tb_axis_array_pkt_mon \
    -o tb_sim

# the log is searched below, so a nonzero exit of the run is not fatal here
./obj_dir/tb_sim 2>&1 | tee sim.log

if grep -qF "*** PASSED ***" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed, see sim.log"
    exit 1
fi
